// ==== tb.f ====
+incdir+source
source/froggerPkg.sv
source/frogMover.sv
source/carTraffic.sv
source/collisions.sv
source/gameKeeper.sv
source/froggerTop.sv
tests/froggerTb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := froggerTb
FILELIST := tb.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard source/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/froggerTb.sv ====
`timescale 1ns/1ps
`include "frogger_defs.svh"

module froggerTb
    import froggerPkg::*;
();

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 8;
    localparam int TickEvery   = 4;
    // Random play then a wait for game over; hard stop well after that
    localparam int StimCycles  = 3000;
    localparam int CycleLimit  = 4000;
    localparam int Tile        = `FROG_TILE;
    localparam int ScreenW     = `FROG_SCREEN_W;
    localparam int ScreenH     = `FROG_SCREEN_H;
    localparam int unsigned RandSeed = 32'h72a2ec46;
    localparam posT StartPos = '{x: 10'(`FROG_START_X), y: 9'(`FROG_START_Y)};

    logic       clk;
    logic       arstN;
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic       tick;
    posT        frog;
    carsT       cars;
    logic       collision;
    logic [1:0] lives;
    logic [7:0] score;
    logic       gameOver;

    // Hidden keeper state rebuilt from the ports
    logic       restartQ;
    logic       collisionQ;
    logic       hitNow;
    logic       crossNow;
    // Expected port values after the next edge
    posT        expFrog;
    carsT       expCars;
    logic       expCollision;
    logic [1:0] expLives;
    logic [7:0] expScore;
    logic       expGameOver;

    int          cycleCount = 0;
    int          frogErrs = 0;
    int          carErrs = 0;
    int          collisionErrs = 0;
    int          livesErrs = 0;
    int          scoreErrs = 0;
    int          overErrs = 0;
    int          hitsSeen = 0;
    int          crossSeen = 0;
    int          games = 1;
    int unsigned leftW = 3;
    logic        overSeen = 1'b0;

    froggerTop i_dut (
        .i_Clk      (clk),
        .i_arstN    (arstN),
        .i_Up       (up),
        .i_Down     (down),
        .i_Left     (left),
        .i_Right    (right),
        .i_Tick     (tick),
        .o_Frog     (frog),
        .o_Cars     (cars),
        .o_Collision(collision),
        .o_Lives    (lives),
        .o_Score    (score),
        .o_GameOver (gameOver)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////

    // Lane of each car
    // Lanes 1 and 3 run right
    function automatic int carLane(input int k);
        case (k)
            0, 4:    return 1;
            1, 5:    return 2;
            2:       return 3;
            default: return 4;
        endcase
    endfunction

    function automatic int laneRow(input int lane);
        case (lane)
            1:       return `FROG_LANE1_Y;
            2:       return `FROG_LANE2_Y;
            3:       return `FROG_LANE3_Y;
            default: return `FROG_LANE4_Y;
        endcase
    endfunction

    function automatic int carSpeed(input int k);
        case (k)
            0:       return `FROG_CAR1_SPEED;
            1:       return `FROG_CAR2_SPEED;
            2:       return `FROG_CAR3_SPEED;
            3:       return `FROG_CAR4_SPEED;
            4:       return `FROG_CAR5_SPEED;
            default: return `FROG_CAR6_SPEED;
        endcase
    endfunction

    function automatic carsT startCars();
        carsT c;
        c[0] = 10'(`FROG_CAR1_X0);
        c[1] = 10'(`FROG_CAR2_X0);
        c[2] = 10'(`FROG_CAR3_X0);
        c[3] = 10'(`FROG_CAR4_X0);
        c[4] = 10'(`FROG_CAR5_X0);
        c[5] = 10'(`FROG_CAR6_X0);
        return c;
    endfunction

    // One tile per pulse with Up first; off-screen moves dropped
    function automatic posT movedFrog(input posT f, input logic u, input logic d,
                                      input logic l, input logic r, input logic restart,
                                      input logic freeze);
        int  x;
        int  y;
        posT n;
        x = int'(f.x);
        y = int'(f.y);
        if (restart)
        begin
            x = `FROG_START_X;
            y = `FROG_START_Y;
        end
        else if (!freeze)
        begin
            if (u)
            begin
                if (y >= Tile) y = y - Tile;
            end
            else if (d)
            begin
                if (y + Tile <= ScreenH - Tile) y = y + Tile;
            end
            else if (l)
            begin
                if (x >= Tile) x = x - Tile;
            end
            else if (r)
            begin
                if (x + Tile <= ScreenW - Tile) x = x + Tile;
            end
        end
        n.x = 10'(x);
        n.y = 9'(y);
        return n;
    endfunction

    function automatic carsT movedCars(input carsT c, input logic t);
        carsT n;
        n = c;
        if (t)
        begin
            for (int k = 0; k < 6; k++)
            begin
                if (carLane(k) % 2 == 1)
                    n[k] = 10'((int'(c[k]) + carSpeed(k)) % ScreenW);
                else
                    n[k] = 10'((int'(c[k]) + ScreenW - carSpeed(k)) % ScreenW);
            end
        end
        return n;
    endfunction

    // Either frog edge inside a car span and frog top inside that car's lane
    function automatic logic anyOverlap(input posT f, input carsT c);
        logic any;
        int   fx;
        int   fy;
        int   cx;
        int   ly;
        any = 1'b0;
        fx  = int'(f.x);
        fy  = int'(f.y);
        for (int k = 0; k < 6; k++)
        begin
            cx = int'(c[k]);
            ly = laneRow(carLane(k));
            if (((fx >= cx && fx < cx + Tile) || (fx + Tile >= cx && fx + Tile < cx + Tile))
                && fy >= ly && fy < ly + Tile)
                any = 1'b1;
        end
        return any;
    endfunction

    // Counted only while playing and outside a restart cycle
    assign hitNow   = collision && !collisionQ && !gameOver && !restartQ;
    assign crossNow = (frog.y == 9'd0) && !gameOver && !restartQ;

    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            restartQ     <= 1'b0;
            collisionQ   <= 1'b0;
            expFrog      <= StartPos;
            expCars      <= startCars();
            expCollision <= 1'b0;
            expLives     <= 2'(`FROG_LIVES);
            expScore     <= 8'd0;
            expGameOver  <= 1'b0;
        end
        else
        begin
            restartQ     <= hitNow || crossNow;
            collisionQ   <= collision;
            expFrog      <= movedFrog(frog, up, down, left, right, restartQ, gameOver);
            expCars      <= movedCars(cars, tick);
            expCollision <= anyOverlap(frog, cars);
            expLives     <= hitNow ? ((lives == 2'd0) ? 2'd0 : lives - 2'd1) : lives;
            expScore     <= crossNow ? score + 8'd1 : score;
            // Last life lost
            expGameOver  <= gameOver || (hitNow && lives <= 2'd1);
            if (hitNow) hitsSeen <= hitsSeen + 1;
            if (crossNow) crossSeen <= crossSeen + 1;
            if (gameOver) overSeen <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    //////////////////////////////////////////////////////////////
    // Checks against the model
    //////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!arstN) frog == expFrog)
        else
        begin
            frogErrs++;
            $display("error %0t: frog at %0d,%0d, expected %0d,%0d", $time,
                     $sampled(frog.x), $sampled(frog.y), $sampled(expFrog.x), $sampled(expFrog.y));
        end

    assert property (@(posedge clk) disable iff (!arstN) cars == expCars)
        else
        begin
            carErrs++;
            $display("error %0t: cars %h, expected %h", $time, $sampled(cars), $sampled(expCars));
        end

    assert property (@(posedge clk) disable iff (!arstN) collision == expCollision)
        else
        begin
            collisionErrs++;
            $display("error %0t: collision %0b, expected %0b", $time,
                     $sampled(collision), $sampled(expCollision));
        end

    assert property (@(posedge clk) disable iff (!arstN) lives == expLives)
        else
        begin
            livesErrs++;
            $display("error %0t: lives %0d, expected %0d", $time,
                     $sampled(lives), $sampled(expLives));
        end

    assert property (@(posedge clk) disable iff (!arstN) score == expScore)
        else
        begin
            scoreErrs++;
            $display("error %0t: score %0d, expected %0d", $time,
                     $sampled(score), $sampled(expScore));
        end

    assert property (@(posedge clk) disable iff (!arstN) gameOver == expGameOver)
        else
        begin
            overErrs++;
            $display("error %0t: game over %0b, expected %0b", $time,
                     $sampled(gameOver), $sampled(expGameOver));
        end

    // No lives left means the game has ended
    assert property (@(posedge clk) disable iff (!arstN) (lives == 2'd0) |-> gameOver)
        else
        begin
            overErrs++;
            $display("error %0t: lives at 0 without game over", $time);
        end

    //////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////

    // Up-heavy presses with overlaps so priority gets exercised
    task automatic driveCycle();
        int unsigned r;
        r = $urandom;
        @(posedge clk);
        up    <= ((r % 16) < 5);
        down  <= (((r >> 4) % 16) < 2);
        left  <= (((r >> 8) % 16) < leftW);
        right <= (((r >> 12) % 16) < 4 - leftW);
        tick  <= ((cycleCount % TickEvery) == 0);
    endtask

    // Only reset starts a fresh game; drift flips side to reach both edges
    task automatic newGame();
        @(posedge clk);
        arstN <= 1'b0;
        up    <= 1'b0;
        down  <= 1'b0;
        left  <= 1'b0;
        right <= 1'b0;
        tick  <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        games++;
        leftW = (games % 2 == 0) ? 1 : 3;
    endtask

    task automatic finishRun(input logic timedOut);
        int   total;
        logic missed;
        total  = frogErrs + carErrs + collisionErrs + livesErrs + scoreErrs + overErrs;
        missed = 1'b0;
        // Hit and crossing checks only mean something once they have fired
        if (hitsSeen == 0)
        begin
            $display("the frog was never hit by a car during the run");
            missed = 1'b1;
        end
        if (crossSeen == 0)
        begin
            $display("the frog never reached the top row during the run");
            missed = 1'b1;
        end
        $write("errors %0d (frog %0d, cars %0d, collision %0d, ",
               total, frogErrs, carErrs, collisionErrs);
        $display("lives %0d, score %0d, over %0d), %0d games, %0d hits, %0d crossings",
                 livesErrs, scoreErrs, overErrs, games, hitsSeen, crossSeen);
        if (total == 0 && !timedOut && !missed)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    initial
    begin
        int frozen;
        frozen = 0;
        void'($urandom(RandSeed));
        arstN = 1'b0;
        up    = 1'b0;
        down  = 1'b0;
        left  = 1'b0;
        right = 1'b0;
        tick  = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        while (cycleCount < StimCycles)
        begin
            driveCycle();
            // Buttons keep coming during game over to check the freeze
            frozen = gameOver ? frozen + 1 : 0;
            if (frozen == 40)
            begin
                newGame();
                frozen = 0;
            end
        end
        while (!gameOver) driveCycle();
        repeat (20) driveCycle();
        finishRun(1'b0);
    end

    initial
    begin
        wait (cycleCount >= CycleLimit);
        if (overSeen)
            $display("timeout: run still going after %0d cycles", CycleLimit);
        else
            $display("timeout: game over never reached in %0d cycles", CycleLimit);
        finishRun(1'b1);
    end

endmodule

// ==== source/froggerTop.sv ====
`timescale 1ns/1ps

module froggerTop
    import froggerPkg::*;
(
    input  logic       i_Clk,
    input  logic       i_arstN,
    // Buttons, already debounced to pulses
    input  logic       i_Up,
    input  logic       i_Down,
    input  logic       i_Left,
    input  logic       i_Right,
    input  logic       i_Tick,
    output posT        o_Frog,
    output carsT       o_Cars,
    output logic       o_Collision,
    output logic [1:0] o_Lives,
    output logic [7:0] o_Score,
    output logic       o_GameOver
);

    // gameKeeper back to frogMover
    logic restart;

    ////////////////////////////////////////////////////////////
    // Play field
    ////////////////////////////////////////////////////////////

    frogMover i_frogMover (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_Up     (i_Up),
        .i_Down   (i_Down),
        .i_Left   (i_Left),
        .i_Right  (i_Right),
        .i_Restart(restart),
        .i_Freeze (o_GameOver),
        .o_Frog   (o_Frog)
    );

    carTraffic i_carTraffic (
        .i_Clk  (i_Clk),
        .i_arstN(i_arstN),
        .i_Tick (i_Tick),
        .o_Cars (o_Cars)
    );

    collisions i_collisions (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Frog     (o_Frog),
        .i_Cars     (o_Cars),
        .o_Collision(o_Collision)
    );

    // Lives, score and restart sequencing
    gameKeeper i_gameKeeper (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Collision(o_Collision),
        .i_Frog     (o_Frog),
        .o_Restart  (restart),
        .o_Lives    (o_Lives),
        .o_Score    (o_Score),
        .o_GameOver (o_GameOver)
    );

endmodule

// ==== source/gameKeeper.sv ====
`timescale 1ns/1ps
`include "frogger_defs.svh"

module gameKeeper
    import froggerPkg::*;
(
    input  logic       i_Clk,
    input  logic       i_arstN,
    input  logic       i_Collision,
    input  posT        i_Frog,
    // One-cycle pulse, frog back to spawn
    output logic       o_Restart,
    output logic [1:0] o_Lives,
    output logic [7:0] o_Score,
    // Sticky until reset
    output logic       o_GameOver
);

    // Collision level of the previous cycle
    logic       collisionQ;
    logic       hit;
    logic       crossing;
    logic [1:0] livesLeft;

    ////////////////////////////////////////////////////////////
    // Event detection
    ////////////////////////////////////////////////////////////

    // New hit on the rising edge only; nothing counts once the game is over
    assign hit = i_Collision && !collisionQ && !o_GameOver && !o_Restart;

    // Top row reached; frog still sits there during the restart cycle
    assign crossing = (i_Frog.y == 9'd0) && !o_GameOver && !o_Restart;

    // Saturate at zero
    assign livesLeft = (o_Lives == 2'd0) ? 2'd0 : o_Lives - 2'd1;

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            collisionQ <= 1'b0;
            o_Restart  <= 1'b0;
            o_Lives    <= 2'(`FROG_LIVES);
            o_Score    <= 8'd0;
            o_GameOver <= 1'b0;
        end
        else
        begin
            collisionQ <= i_Collision;
            o_Restart  <= hit || crossing;
            if (hit)
            begin
                o_Lives <= livesLeft;
                // Last life gone
                if (livesLeft == 2'd0)
                begin
                    o_GameOver <= 1'b1;
                end
            end
            if (crossing)
            begin
                // Wraps after 255
                o_Score <= o_Score + 8'd1;
            end
        end
    end

    // Restart is a single-cycle pulse
    assert property (@(posedge i_Clk) disable iff (!i_arstN) o_Restart |=> !o_Restart)
        else $error("gameKeeper: restart held for two cycles");

    // Game over is sticky
    assert property (@(posedge i_Clk) disable iff (!i_arstN) o_GameOver |=> o_GameOver)
        else $error("gameKeeper: game over dropped");

endmodule

// ==== source/collisions.sv ====
`timescale 1ns/1ps
`include "frogger_defs.svh"

module collisions
    import froggerPkg::*;
(
    input  logic i_Clk,
    input  logic i_arstN,
    input  posT  i_Frog,
    input  carsT i_Cars,
    // Frog touches a car, one cycle behind its inputs
    output logic o_Collision
);

    localparam logic [10:0] Tile = 11'(`FROG_TILE);

    // Lane row per car, cars 5 and 6 share lanes 1 and 2
    localparam logic [9:0] LaneRow [6] = '{
        10'(`FROG_LANE1_Y), 10'(`FROG_LANE2_Y), 10'(`FROG_LANE3_Y),
        10'(`FROG_LANE4_Y), 10'(`FROG_LANE1_Y), 10'(`FROG_LANE2_Y)
    };

    logic [5:0] carHits;

    ////////////////////////////////////////////////////////////
    // Overlap rule
    ////////////////////////////////////////////////////////////

    // Frog left or right edge inside the car span, frog top inside the lane
    // No check across the wrap point
    function automatic logic carHit(input logic [9:0] carX, input logic [9:0] laneY,
                                    input posT frog);
        logic [10:0] frogL;
        logic [10:0] frogR;
        logic [10:0] carL;
        logic [10:0] carR;
        logic        hitX;
        logic        hitY;
        // Widened by one bit so X plus a tile cannot wrap
        frogL = {1'b0, frog.x};
        frogR = frogL + Tile;
        carL  = {1'b0, carX};
        carR  = carL + Tile;
        hitX  = ((frogL >= carL) && (frogL < carR)) || ((frogR >= carL) && (frogR < carR));
        hitY  = ({1'b0, frog.y} >= laneY) && ({1'b0, frog.y} < laneY + Tile[9:0]);
        return hitX && hitY;
    endfunction

    always_comb
    begin
        for (int k = 0; k < 6; k++)
        begin
            carHits[k] = carHit(i_Cars[k], LaneRow[k], i_Frog);
        end
    end

    // Any of the six cars
    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            o_Collision <= 1'b0;
        end
        else
        begin
            o_Collision <= |carHits;
        end
    end

endmodule

// ==== source/carTraffic.sv ====
`timescale 1ns/1ps
`include "frogger_defs.svh"

module carTraffic
    import froggerPkg::*;
(
    input  logic i_Clk,
    input  logic i_arstN,
    // Frame strobe, one cycle
    input  logic i_Tick,
    output carsT o_Cars
);

    localparam int NumCars = 6;
    localparam logic [9:0] ScreenW = 10'(`FROG_SCREEN_W);

    // Per-car step size
    localparam logic [9:0] CarSpeed [NumCars] = '{
        10'(`FROG_CAR1_SPEED), 10'(`FROG_CAR2_SPEED), 10'(`FROG_CAR3_SPEED),
        10'(`FROG_CAR4_SPEED), 10'(`FROG_CAR5_SPEED), 10'(`FROG_CAR6_SPEED)
    };
    localparam logic [9:0] CarStart [NumCars] = '{
        10'(`FROG_CAR1_X0), 10'(`FROG_CAR2_X0), 10'(`FROG_CAR3_X0),
        10'(`FROG_CAR4_X0), 10'(`FROG_CAR5_X0), 10'(`FROG_CAR6_X0)
    };
    // Cars 1, 3, 5 sit in lanes 1 and 3, moving right
    localparam logic [NumCars-1:0] GoesRight = 6'b010101;

    carsT carsNext;

    ////////////////////////////////////////////////////////////
    // Step with wrap at the screen width
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < NumCars; k++)
        begin
            if (GoesRight[k])
            begin
                // Past the right edge, reappear on the left
                if (o_Cars[k] >= ScreenW - CarSpeed[k])
                begin
                    carsNext[k] = o_Cars[k] + CarSpeed[k] - ScreenW;
                end
                else
                begin
                    carsNext[k] = o_Cars[k] + CarSpeed[k];
                end
            end
            else
            begin
                // Below zero, wrap to the right end
                if (o_Cars[k] >= CarSpeed[k])
                begin
                    carsNext[k] = o_Cars[k] - CarSpeed[k];
                end
                else
                begin
                    carsNext[k] = o_Cars[k] + ScreenW - CarSpeed[k];
                end
            end
        end
    end

    // Hold between ticks
    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            for (int k = 0; k < NumCars; k++)
            begin
                o_Cars[k] <= CarStart[k];
            end
        end
        else if (i_Tick)
        begin
            o_Cars <= carsNext;
        end
    end

    // Wrap logic keeps every car on the field
    for (genvar k = 0; k < NumCars; k++)
    begin : gCarRange
        assert property (@(posedge i_Clk) disable iff (!i_arstN) o_Cars[k] < ScreenW)
            else $error("carTraffic: car %0d at X %0d", k + 1, o_Cars[k]);
    end

endmodule

// ==== source/frogMover.sv ====
`timescale 1ns/1ps
`include "frogger_defs.svh"

module frogMover
    import froggerPkg::*;
(
    input  logic i_Clk,
    input  logic i_arstN,
    // One-cycle button pulses
    input  logic i_Up,
    input  logic i_Down,
    input  logic i_Left,
    input  logic i_Right,
    // Back to spawn after a hit or a crossing
    input  logic i_Restart,
    // Game over, buttons dead
    input  logic i_Freeze,
    output posT  o_Frog
);

    // One tile per step
    localparam logic [9:0] StepX = 10'(`FROG_TILE);
    localparam logic [8:0] StepY = 9'(`FROG_TILE);
    // Last legal top-left corner
    localparam logic [9:0] MaxX = 10'(`FROG_SCREEN_W - `FROG_TILE);
    localparam logic [8:0] MaxY = 9'(`FROG_SCREEN_H - `FROG_TILE);
    localparam posT StartPos = '{x: 10'(`FROG_START_X), y: 9'(`FROG_START_Y)};

    posT frogNext;

    ////////////////////////////////////////////////////////////
    // Next position, Up > Down > Left > Right
    ////////////////////////////////////////////////////////////

    // Winning button only; a blocked move is dropped
    always_comb
    begin
        frogNext = o_Frog;
        if (i_Up)
        begin
            if (o_Frog.y >= StepY)
            begin
                frogNext.y = o_Frog.y - StepY;
            end
        end
        else if (i_Down)
        begin
            // Keep the whole tile on screen
            if (o_Frog.y <= MaxY - StepY)
            begin
                frogNext.y = o_Frog.y + StepY;
            end
        end
        else if (i_Left)
        begin
            if (o_Frog.x >= StepX)
            begin
                frogNext.x = o_Frog.x - StepX;
            end
        end
        else if (i_Right)
        begin
            if (o_Frog.x <= MaxX - StepX)
            begin
                frogNext.x = o_Frog.x + StepX;
            end
        end
    end

    // Restart wins over any button in the same cycle
    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            o_Frog <= StartPos;
        end
        else if (i_Restart)
        begin
            o_Frog <= StartPos;
        end
        else if (!i_Freeze)
        begin
            o_Frog <= frogNext;
        end
    end

    // Frog always sits on the tile grid inside the field
    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        ((o_Frog.x % StepX) == 10'd0) && ((o_Frog.y % StepY) == 9'd0) &&
        (o_Frog.x <= MaxX) && (o_Frog.y <= MaxY))
        else $error("frogMover: frog off grid at %0d,%0d", o_Frog.x, o_Frog.y);

endmodule

// ==== source/froggerPkg.sv ====
package froggerPkg;

    ////////////////////////////////////////////////////////////
    // Play-field coordinates
    ////////////////////////////////////////////////////////////

    // Top-left corner of a sprite on the 640x480 field
    // 10 bits cover X up to 639, 9 bits cover Y up to 479
    typedef struct packed
    {
        logic [9:0] x;
        logic [8:0] y;
    } posT;

    ////////////////////////////////////////////////////////////
    // Traffic
    ////////////////////////////////////////////////////////////

    // Left edge X of the six cars
    // Index 0 is car 1; lane rows are fixed per index
    typedef logic [5:0][9:0] carsT;

endpackage

// ==== source/frogger_defs.svh ====
`ifndef FROGGER_DEFS_SVH
`define FROGGER_DEFS_SVH

// Screen and tile geometry in pixels
`define FROG_TILE       32
`define FROG_SCREEN_W   640
`define FROG_SCREEN_H   480

// Top row of each traffic lane
`define FROG_LANE1_Y    128
`define FROG_LANE2_Y    192
`define FROG_LANE3_Y    256
`define FROG_LANE4_Y    320

// Frog spawn point, bottom middle of the field
`define FROG_START_X    320
`define FROG_START_Y    448
`define FROG_LIVES      3

// Pixels per frame tick, car 1 to car 6
`define FROG_CAR1_SPEED 2
`define FROG_CAR2_SPEED 3
`define FROG_CAR3_SPEED 4
`define FROG_CAR4_SPEED 1
`define FROG_CAR5_SPEED 2
`define FROG_CAR6_SPEED 3

// Car X after reset
`define FROG_CAR1_X0    0
`define FROG_CAR2_X0    96
`define FROG_CAR3_X0    200
`define FROG_CAR4_X0    400
`define FROG_CAR5_X0    320
`define FROG_CAR6_X0    500

`endif
